/* dv/im2col_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_tb
  import im2col_pkg::*;
();

  localparam int unsigned RESET_LIMIT = 64;
  localparam int unsigned PUSH_LIMIT  = 2000;
  localparam int unsigned DONE_LIMIT  = 6000;

  typedef struct packed {
    logic [PAD_W-1:0]    top_pad;
    logic [PAD_W-1:0]    bottom_pad;
    logic [PAD_W-1:0]    left_pad;
    logic [PAD_W-1:0]    right_pad;
    logic [31:0]         in_ptr;
    logic [31:0]         out_ptr;
    logic [INC_D2_W-1:0] in_inc_d2;
    logic [SIZE_W-1:0]   size_d1;
    logic [SIZE_W-1:0]   size_d2;
  } desc_t;

  logic                  clk;
  logic                  rst_n;
  data_type_e            data_type;
  logic [STRIDE_W-1:0]   log_stride;
  logic [SLOT_W-1:0]     tx_slot;
  logic [SLOT_W-1:0]     rx_slot;
  logic [DMA_CH_NUM-1:0] ch_mask;
  logic                  irq_en;
  logic                  start;
  logic                  stream_end;
  logic                  irq_clear;
  logic                  desc_push;
  desc_t                 desc;
  logic                  desc_full;
  logic                  wr_req;
  logic [31:0]           wr_addr;
  logic [31:0]           wr_data;
  logic                  wr_done;
  logic [DMA_CH_NUM-1:0] dma_done;
  logic                  busy;
  logic                  done;
  logic                  irq;

  // Reference model state
  logic [15:0]           lfsr_q;
  desc_t                 desc_q[$];
  logic [31:0]           exp_addr[$];
  logic [31:0]           exp_data[$];
  logic [DMA_CH_NUM-1:0] mbusy;
  logic [DMA_CH_NUM-1:0] mfirst;
  logic                  armed;
  int unsigned           wait_cnt;
  int unsigned           cur_ch;
  int unsigned           unpopped;
  int unsigned           pop_delay;
  int unsigned           picked;
  int unsigned           pushed_cnt;
  int unsigned           run_total;
  int unsigned           done_cnt;
  logic                  busy_exp;
  logic                  irq_exp;
  logic                  end_sent;

  im2col_tb_clk u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  im2col_top DUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .data_type_i       (data_type),
    .log_stride_i      (log_stride),
    .tx_slot_i         (tx_slot),
    .rx_slot_i         (rx_slot),
    .ch_mask_i         (ch_mask),
    .irq_en_i          (irq_en),
    .start_i           (start),
    .stream_end_i      (stream_end),
    .irq_clear_i       (irq_clear),
    .desc_push_i       (desc_push),
    .desc_top_pad_i    (desc.top_pad),
    .desc_bottom_pad_i (desc.bottom_pad),
    .desc_left_pad_i   (desc.left_pad),
    .desc_right_pad_i  (desc.right_pad),
    .desc_in_ptr_i     (desc.in_ptr),
    .desc_out_ptr_i    (desc.out_ptr),
    .desc_in_inc_d2_i  (desc.in_inc_d2),
    .desc_size_d1_i    (desc.size_d1),
    .desc_size_d2_i    (desc.size_d2),
    .desc_full_o       (desc_full),
    .wr_req_o          (wr_req),
    .wr_addr_o         (wr_addr),
    .wr_data_o         (wr_data),
    .wr_done_i         (wr_done),
    .dma_done_i        (dma_done),
    .busy_o            (busy),
    .done_o            (done),
    .irq_o             (irq)
  );

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  function automatic logic [31:0] draw(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic add_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // Expected register writes of one descriptor in DMA order
  task automatic queue_writes(input desc_t d, input int unsigned ch, input logic first_used);
    logic [1:0]  dt;
    logic [1:0]  s;
    logic [31:0] base;
    dt   = data_type;
    s    = 2'd2 - dt;
    base = DMA_BASE_ADDR + 32'(ch) * DMA_CH_SIZE;
    if (!first_used) begin
      add_write(base + DMA_DIM_OFFSET, 32'd1);
      add_write(base + DMA_SLOTS_OFFSET, {tx_slot, rx_slot});
      add_write(base + DMA_SRC_DT_OFFSET, 32'(dt));
      add_write(base + DMA_DST_DT_OFFSET, 32'(dt));
    end
    add_write(base + DMA_TOP_PAD_OFFSET, (32'(d.top_pad) << s) & MASK_PAD);
    add_write(base + DMA_BOTTOM_PAD_OFFSET, (32'(d.bottom_pad) << s) & MASK_PAD);
    add_write(base + DMA_LEFT_PAD_OFFSET, (32'(d.left_pad) << s) & MASK_PAD);
    add_write(base + DMA_RIGHT_PAD_OFFSET, (32'(d.right_pad) << s) & MASK_PAD);
    add_write(base + DMA_SRC_PTR_OFFSET, d.in_ptr);
    add_write(base + DMA_DST_PTR_OFFSET, d.out_ptr);
    add_write(base + DMA_SRC_INC_D1_OFFSET, ((32'd1 << log_stride) << s) & MASK_PAD);
    add_write(base + DMA_SRC_INC_D2_OFFSET, (32'(d.in_inc_d2) << s) & MASK_INC_D2);
    add_write(base + DMA_DST_INC_D1_OFFSET, (32'd4 >> dt) & MASK_PAD);
    add_write(base + DMA_DST_INC_D2_OFFSET, (32'd4 >> dt) & MASK_INC_D2);
    add_write(base + DMA_SIZE_D2_OFFSET, (32'(d.size_d2) << s) & MASK_SIZE);
    add_write(base + DMA_SIZE_D1_OFFSET, (32'(d.size_d1) << s) & MASK_SIZE);
  endtask

  // Next descriptor goes to the lowest enabled channel that is free
  task automatic start_descriptor();
    desc_t d;
    int    ch;
    if (desc_q.size() == 0) begin
      stop_on_error("Write request appeared with no descriptor waiting");
    end
    d  = desc_q.pop_front();
    ch = -1;
    for (int i = DMA_CH_NUM - 1; i >= 0; i--) begin
      if (ch_mask[i] && !mbusy[i]) begin
        ch = i;
      end
    end
    if (ch < 0) begin
      stop_on_error("Write request appeared while every enabled channel was busy");
    end
    queue_writes(d, ch, mfirst[ch]);
    mbusy[ch]  = 1'b1;
    mfirst[ch] = 1'b1;
    cur_ch     = ch;
    picked++;
  endtask

  // Per-cycle checks, write responder and channel release
  task automatic service_cycle();
    int unsigned rel_ch;
    logic        can_release;
    if (pop_delay > 0) begin
      pop_delay--;
      if (pop_delay == 0) begin
        unpopped--;
      end
    end
    check_value("desc_full_o", desc_full, unpopped == FIFO_DEPTH);
    if (done) begin
      if (!end_sent || picked != run_total || exp_addr.size() != 0 || mbusy != '0) begin
        stop_on_error("Done pulsed before the stream had ended and drained");
      end
      done_cnt++;
      if (irq_en) begin
        irq_exp = 1'b1;
      end
    end
    check_value("busy_o", busy, busy_exp);
    check_value("irq_o", irq, irq_exp);
    if (done) begin
      busy_exp = 1'b0;
    end
    if (wr_req) begin
      if (!armed) begin
        if (exp_addr.size() == 0) begin
          start_descriptor();
        end
        armed    = 1'b1;
        wait_cnt = draw(2);
      end
      check_value("wr_addr_o", wr_addr, exp_addr[0]);
      check_value("wr_data_o", wr_data, exp_data[0]);
      if (wait_cnt == 0) begin
        wr_done = 1'b1;
        armed   = 1'b0;
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        if (exp_addr.size() == 0) begin
          pop_delay = 2;
        end
      end else begin
        wait_cnt--;
      end
    end else if (exp_addr.size() != 0) begin
      stop_on_error("Write sequence stopped before every register was written");
    end
    // Releases only where no channel pick can happen at the next edge
    can_release = wr_req || ((ch_mask & ~mbusy) == '0) || (picked == run_total);
    if (can_release) begin
      rel_ch = draw(2);
      if (mbusy[rel_ch] && !(wr_req && rel_ch == cur_ch)) begin
        dma_done[rel_ch] = 1'b1;
        mbusy[rel_ch]    = 1'b0;
      end
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
    start      = 1'b0;
    stream_end = 1'b0;
    irq_clear  = 1'b0;
    desc_push  = 1'b0;
    wr_done    = 1'b0;
    dma_done   = '0;
    service_cycle();
  endtask

  task automatic push_desc();
    desc_t       d;
    int unsigned waited;
    waited = 0;
    tick();
    while (unpopped >= FIFO_DEPTH) begin
      if (waited == PUSH_LIMIT) begin
        stop_on_error("Descriptor FIFO stayed full for too long");
      end
      waited++;
      tick();
    end
    d.top_pad    = draw(PAD_W);
    d.bottom_pad = draw(PAD_W);
    d.left_pad   = draw(PAD_W);
    d.right_pad  = draw(PAD_W);
    d.in_ptr     = draw(32);
    d.out_ptr    = draw(32);
    d.in_inc_d2  = draw(INC_D2_W);
    d.size_d1    = draw(SIZE_W);
    d.size_d2    = draw(SIZE_W);
    desc         = d;
    desc_push    = 1'b1;
    desc_q.push_back(d);
    unpopped++;
    pushed_cnt++;
  endtask

  // One run from start to done with descriptors pushed in random bursts
  task automatic run_stream(input logic [1:0] dt, input logic [DMA_CH_NUM-1:0] mask,
                            input logic irq_on, input int unsigned total);
    int unsigned burst;
    int unsigned gap;
    int unsigned waited;
    tick();
    data_type  = data_type_e'(dt);
    log_stride = draw(STRIDE_W);
    tx_slot    = draw(SLOT_W);
    rx_slot    = draw(SLOT_W);
    ch_mask    = mask;
    irq_en     = irq_on;
    tick();
    start      = 1'b1;
    mbusy      = '0;
    mfirst     = '0;
    busy_exp   = 1'b1;
    end_sent   = 1'b0;
    picked     = 0;
    pushed_cnt = 0;
    run_total  = total;
    done_cnt   = 0;
    while (pushed_cnt < total) begin
      burst = 1 + draw(3);
      while (burst > 0 && pushed_cnt < total) begin
        push_desc();
        burst--;
      end
      gap = draw(3);
      repeat (gap) tick();
    end
    tick();
    stream_end = 1'b1;
    end_sent   = 1'b1;
    waited     = 0;
    while (done_cnt == 0) begin
      if (waited == DONE_LIMIT) begin
        stop_on_error("Done did not pulse after the stream ended");
      end
      waited++;
      tick();
    end
    repeat (6) tick();
    check_value("done_o pulse count", done_cnt, 32'd1);
    tick();
    irq_clear = 1'b1;
    irq_exp   = 1'b0;
    tick();
    tick();
  endtask

  initial begin
    int unsigned    waited;
    logic [1:0]     dt;
    logic [3:0]     mask;
    data_type  = DT_WORD;
    log_stride = '0;
    tx_slot    = '0;
    rx_slot    = '0;
    ch_mask    = '0;
    irq_en     = 1'b0;
    start      = 1'b0;
    stream_end = 1'b0;
    irq_clear  = 1'b0;
    desc_push  = 1'b0;
    desc       = '0;
    wr_done    = 1'b0;
    dma_done   = '0;
    lfsr_q     = 16'd63199;
    mbusy      = '0;
    mfirst     = '0;
    armed      = 1'b0;
    wait_cnt   = 0;
    cur_ch     = 0;
    unpopped   = 0;
    pop_delay  = 0;
    picked     = 0;
    pushed_cnt = 0;
    run_total  = 0;
    done_cnt   = 0;
    busy_exp   = 1'b0;
    irq_exp    = 1'b0;
    end_sent   = 1'b0;
    waited     = 0;
    while (rst_n !== 1'b1) begin
      if (waited == RESET_LIMIT) begin
        stop_on_error("Reset was never released");
      end
      waited++;
      @(posedge clk);
    end
    tick();
    check_value("wr_req_o", wr_req, 32'd0);
    check_value("done_o", done, 32'd0);

    // Single descriptors, one per data type
    run_stream(2'd0, 4'hF, 1'b1, 1);
    run_stream(2'd1, 4'hF, 1'b0, 1);
    run_stream(2'd2, 4'hF, 1'b1, 1);

    // Channel reuse skips the static registers until the next start
    run_stream(2'd1, 4'b0001, 1'b0, 3);
    run_stream(2'd2, 4'b0001, 1'b1, 1);

    // Random masks, data types and burst lengths
    for (int r = 0; r < 6; r++) begin
      dt = draw(2);
      if (dt == 2'd3) begin
        dt = 2'd0;
      end
      mask = draw(4);
      if (mask == 4'd0) begin
        mask = 4'b0100;
      end
      run_stream(dt, mask, draw(1), 4 + draw(4));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/im2col_tb_clk.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for 16 rising edges
  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/im2col_pkg.sv
verilog/im2col_desc_fifo.sv
verilog/im2col_channel_tracker.sv
verilog/im2col_dma_loader.sv
verilog/im2col_completion.sv
verilog/im2col_top.sv
dv/im2col_tb_clk.sv
dv/im2col_tb.sv

/* verilog/im2col_channel_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_channel_tracker
  import im2col_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    alloc_i,
  input  logic [DMA_CH_NUM-1:0]   ch_mask_i,
  input  logic [DMA_CH_NUM-1:0]   dma_done_i,
  output logic [DMA_CH_IDX_W-1:0] free_ch_o,
  output logic                    ch_full_o,
  output logic                    first_used_o,
  output logic                    any_busy_o
);

  logic [DMA_CH_NUM-1:0]   busy_q;
  logic [DMA_CH_NUM-1:0]   first_used_q;
  logic [DMA_CH_NUM-1:0]   avail;
  logic [DMA_CH_IDX_W-1:0] lowest_free;
  logic [DMA_CH_IDX_W-1:0] work_ch_q;

  // Enabled channels that carry no transfer
  assign avail = ch_mask_i & ~busy_q;

  // Scan from the top so the lowest index wins
  always_comb begin
    lowest_free = '0;
    for (int i = DMA_CH_NUM - 1; i >= 0; i--) begin
      if (avail[i]) begin
        lowest_free = DMA_CH_IDX_W'(i);
      end
    end
  end

  assign ch_full_o    = ~|avail;
  assign any_busy_o   = |busy_q;
  // Decides whether the claimed channel still needs its static registers
  assign first_used_o = first_used_q[lowest_free];
  assign free_ch_o    = work_ch_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= '0;
      first_used_q <= '0;
      work_ch_q    <= '0;
    end else begin
      // Channel completion frees a busy channel
      busy_q <= busy_q & ~dma_done_i;
      if (alloc_i) begin
        busy_q[lowest_free]       <= 1'b1;
        first_used_q[lowest_free] <= 1'b1;
        work_ch_q                 <= lowest_free;
      end
      // A new run forgets all occupancy
      if (clear_i) begin
        busy_q       <= '0;
        first_used_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/im2col_completion.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_completion
  import im2col_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic stream_end_i,
  input  logic fifo_empty_i,
  input  logic loader_idle_i,
  input  logic any_ch_busy_i,
  input  logic irq_en_i,
  input  logic irq_clear_i,
  output logic stream_closed_o,
  output logic busy_o,
  output logic done_o,
  output logic irq_o
);

  logic end_seen_q;
  logic closed_q;
  logic busy_q;
  logic done_q;
  logic irq_q;
  logic done_d;

  // Everything drained and every channel released
  assign done_d = end_seen_q & fifo_empty_i & loader_idle_i & ~any_ch_busy_i & ~done_q;

  assign stream_closed_o = closed_q;
  assign busy_o          = busy_q;
  assign done_o          = done_q;
  assign irq_o           = irq_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_seen_q <= 1'b0;
      closed_q   <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      done_q <= done_d;
      if (start_i) begin
        end_seen_q <= 1'b0;
      end else if (stream_end_i) begin
        end_seen_q <= 1'b1;
      end else if (done_q) begin
        end_seen_q <= 1'b0;
      end
      // No further picks once the stream has ended and drained
      if (start_i) begin
        closed_q <= 1'b0;
      end else if (end_seen_q && fifo_empty_i && loader_idle_i) begin
        closed_q <= 1'b1;
      end
      if (start_i) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
      if (done_d && irq_en_i) begin
        irq_q <= 1'b1;
      end else if (irq_clear_i) begin
        irq_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/im2col_desc_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_desc_fifo
  import im2col_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic [PAD_W-1:0]    top_pad_i,
  input  logic [PAD_W-1:0]    bottom_pad_i,
  input  logic [PAD_W-1:0]    left_pad_i,
  input  logic [PAD_W-1:0]    right_pad_i,
  input  logic [31:0]         in_ptr_i,
  input  logic [31:0]         out_ptr_i,
  input  logic [INC_D2_W-1:0] in_inc_d2_i,
  input  logic [SIZE_W-1:0]   size_d1_i,
  input  logic [SIZE_W-1:0]   size_d2_i,
  output logic [PAD_W-1:0]    top_pad_o,
  output logic [PAD_W-1:0]    bottom_pad_o,
  output logic [PAD_W-1:0]    left_pad_o,
  output logic [PAD_W-1:0]    right_pad_o,
  output logic [31:0]         in_ptr_o,
  output logic [31:0]         out_ptr_o,
  output logic [INC_D2_W-1:0] in_inc_d2_o,
  output logic [SIZE_W-1:0]   size_d1_o,
  output logic [SIZE_W-1:0]   size_d2_o,
  output logic                empty_o,
  output logic                full_o
);

  localparam int unsigned PTR_W   = $clog2(FIFO_DEPTH);
  localparam int unsigned ENTRY_W = 4 * PAD_W + 64 + INC_D2_W + 2 * SIZE_W;

  logic [ENTRY_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W:0]     count_q;
  logic               do_push;
  logic               do_pop;

  assign full_o  = (count_q == (PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  // A push while full is dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry falls through to the outputs
  assign {top_pad_o, bottom_pad_o, left_pad_o, right_pad_o, in_ptr_o, out_ptr_o,
          in_inc_d2_o, size_d1_o, size_d2_o} = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= {top_pad_i, bottom_pad_i, left_pad_i, right_pad_i, in_ptr_i,
                          out_ptr_i, in_inc_d2_i, size_d1_i, size_d2_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/im2col_dma_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_dma_loader
  import im2col_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fifo_empty_i,
  input  logic [PAD_W-1:0]        top_pad_i,
  input  logic [PAD_W-1:0]        bottom_pad_i,
  input  logic [PAD_W-1:0]        left_pad_i,
  input  logic [PAD_W-1:0]        right_pad_i,
  input  logic [31:0]             in_ptr_i,
  input  logic [31:0]             out_ptr_i,
  input  logic [INC_D2_W-1:0]     in_inc_d2_i,
  input  logic [SIZE_W-1:0]       size_d1_i,
  input  logic [SIZE_W-1:0]       size_d2_i,
  input  logic [DMA_CH_IDX_W-1:0] work_ch_i,
  input  logic                    ch_full_i,
  input  logic                    first_used_i,
  input  logic                    stream_closed_i,
  input  data_type_e              data_type_i,
  input  logic [STRIDE_W-1:0]     log_stride_i,
  input  logic [SLOT_W-1:0]       tx_slot_i,
  input  logic [SLOT_W-1:0]       rx_slot_i,
  input  logic                    wr_done_i,
  output logic                    fifo_pop_o,
  output logic                    alloc_o,
  output logic                    idle_o,
  output logic                    wr_req_o,
  output logic [31:0]             wr_addr_o,
  output logic [31:0]             wr_data_o
);

  ctrl_state_e ctrl_q;
  ctrl_state_e ctrl_d;
  load_step_e  step_q;
  load_step_e  step_d;
  logic        can_pick;
  logic        load_done;
  logic [1:0]  shamt;
  logic [31:0] ch_base;
  logic [31:0] offset;

  assign can_pick  = ~fifo_empty_i & ~ch_full_i & ~stream_closed_i;
  assign load_done = (step_q == LOAD_DONE);
  // Element counts become byte counts
  assign shamt     = 2'd2 - data_type_i;
  assign ch_base   = DMA_BASE_ADDR + {{(32 - DMA_CH_IDX_W){1'b0}}, work_ch_i} * DMA_CH_SIZE;

  assign fifo_pop_o = load_done;
  assign alloc_o    = (ctrl_q == CTRL_GET) & can_pick;
  assign idle_o     = (ctrl_q == CTRL_IDLE);
  assign wr_req_o   = (step_q != LOAD_IDLE) & ~load_done;
  assign wr_addr_o  = ch_base + offset;

  always_comb begin
    ctrl_d = ctrl_q;
    unique case (ctrl_q)
      CTRL_IDLE: begin
        if (can_pick) begin
          ctrl_d = CTRL_GET;
        end
      end
      CTRL_GET: begin
        ctrl_d = can_pick ? CTRL_LOAD : CTRL_IDLE;
      end
      CTRL_LOAD: begin
        if (load_done) begin
          ctrl_d = CTRL_IDLE;
        end
      end
      default: ctrl_d = CTRL_IDLE;
    endcase
  end

  // A channel that was already programmed skips the static registers
  always_comb begin
    step_d = step_q;
    if (alloc_o) begin
      step_d = first_used_i ? LOAD_TOP_PAD : LOAD_DIM;
    end else if (load_done) begin
      step_d = LOAD_IDLE;
    end else if (wr_req_o && wr_done_i) begin
      step_d = load_step_e'(step_q + 5'd1);
    end
  end

  // Register offset and payload of the current step
  always_comb begin
    offset    = '0;
    wr_data_o = '0;
    unique case (step_q)
      LOAD_DIM: begin
        offset    = DMA_DIM_OFFSET;
        wr_data_o = 32'd1;
      end
      LOAD_SLOTS: begin
        offset    = DMA_SLOTS_OFFSET;
        wr_data_o = {tx_slot_i, rx_slot_i};
      end
      LOAD_SRC_DT: begin
        offset    = DMA_SRC_DT_OFFSET;
        wr_data_o = {30'd0, data_type_i};
      end
      LOAD_DST_DT: begin
        offset    = DMA_DST_DT_OFFSET;
        wr_data_o = {30'd0, data_type_i};
      end
      LOAD_TOP_PAD: begin
        offset    = DMA_TOP_PAD_OFFSET;
        wr_data_o = ({24'd0, top_pad_i} << shamt) & MASK_PAD;
      end
      LOAD_BOTTOM_PAD: begin
        offset    = DMA_BOTTOM_PAD_OFFSET;
        wr_data_o = ({24'd0, bottom_pad_i} << shamt) & MASK_PAD;
      end
      LOAD_LEFT_PAD: begin
        offset    = DMA_LEFT_PAD_OFFSET;
        wr_data_o = ({24'd0, left_pad_i} << shamt) & MASK_PAD;
      end
      LOAD_RIGHT_PAD: begin
        offset    = DMA_RIGHT_PAD_OFFSET;
        wr_data_o = ({24'd0, right_pad_i} << shamt) & MASK_PAD;
      end
      LOAD_SRC_PTR: begin
        offset    = DMA_SRC_PTR_OFFSET;
        wr_data_o = in_ptr_i;
      end
      LOAD_DST_PTR: begin
        offset    = DMA_DST_PTR_OFFSET;
        wr_data_o = out_ptr_i;
      end
      LOAD_SRC_INC_D1: begin
        offset    = DMA_SRC_INC_D1_OFFSET;
        wr_data_o = ((32'd1 << log_stride_i) << shamt) & MASK_PAD;
      end
      LOAD_SRC_INC_D2: begin
        offset    = DMA_SRC_INC_D2_OFFSET;
        wr_data_o = ({9'd0, in_inc_d2_i} << shamt) & MASK_INC_D2;
      end
      LOAD_DST_INC_D1: begin
        offset    = DMA_DST_INC_D1_OFFSET;
        wr_data_o = (32'd4 >> data_type_i) & MASK_PAD;
      end
      LOAD_DST_INC_D2: begin
        offset    = DMA_DST_INC_D2_OFFSET;
        wr_data_o = (32'd4 >> data_type_i) & MASK_INC_D2;
      end
      LOAD_SIZE_D2: begin
        offset    = DMA_SIZE_D2_OFFSET;
        wr_data_o = ({16'd0, size_d2_i} << shamt) & MASK_SIZE;
      end
      LOAD_SIZE_D1: begin
        offset    = DMA_SIZE_D1_OFFSET;
        wr_data_o = ({16'd0, size_d1_i} << shamt) & MASK_SIZE;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= CTRL_IDLE;
      step_q <= LOAD_IDLE;
    end else begin
      ctrl_q <= ctrl_d;
      step_q <= step_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/im2col_pkg.sv */
`default_nettype none

package im2col_pkg;

  // DMA and descriptor queue sizing
  localparam int unsigned DMA_CH_NUM   = 4;
  localparam int unsigned DMA_CH_IDX_W = 2;
  localparam int unsigned FIFO_DEPTH   = 8;

  localparam logic [31:0] DMA_BASE_ADDR = 32'h5000_0000;
  localparam logic [31:0] DMA_CH_SIZE   = 32'h0000_0100;

  // Per-channel DMA register offsets
  localparam logic [31:0] DMA_DIM_OFFSET        = 32'h3C;
  localparam logic [31:0] DMA_SLOTS_OFFSET      = 32'h28;
  localparam logic [31:0] DMA_SRC_DT_OFFSET     = 32'h2C;
  localparam logic [31:0] DMA_DST_DT_OFFSET     = 32'h30;
  localparam logic [31:0] DMA_TOP_PAD_OFFSET    = 32'h44;
  localparam logic [31:0] DMA_BOTTOM_PAD_OFFSET = 32'h48;
  localparam logic [31:0] DMA_LEFT_PAD_OFFSET   = 32'h4C;
  localparam logic [31:0] DMA_RIGHT_PAD_OFFSET  = 32'h50;
  localparam logic [31:0] DMA_SRC_PTR_OFFSET    = 32'h0;
  localparam logic [31:0] DMA_DST_PTR_OFFSET    = 32'h4;
  localparam logic [31:0] DMA_SRC_INC_D1_OFFSET = 32'h18;
  localparam logic [31:0] DMA_SRC_INC_D2_OFFSET = 32'h1C;
  localparam logic [31:0] DMA_DST_INC_D1_OFFSET = 32'h20;
  localparam logic [31:0] DMA_DST_INC_D2_OFFSET = 32'h24;
  localparam logic [31:0] DMA_SIZE_D2_OFFSET    = 32'h10;
  localparam logic [31:0] DMA_SIZE_D1_OFFSET    = 32'hC;

  // Register field masks
  localparam logic [31:0] MASK_PAD    = 32'h0000_003F;
  localparam logic [31:0] MASK_INC_D2 = 32'h007F_FFFF;
  localparam logic [31:0] MASK_SIZE   = 32'h0000_FFFF;

  // Descriptor and configuration field widths
  localparam int unsigned PAD_W    = 8;
  localparam int unsigned INC_D2_W = 23;
  localparam int unsigned SIZE_W   = 16;
  localparam int unsigned SLOT_W   = 16;
  localparam int unsigned STRIDE_W = 4;
  localparam int unsigned DTYPE_W  = 2;

  // Element counts are shifted left by two minus the element width code
  typedef enum logic [DTYPE_W-1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2
  } data_type_e;

  // Register writes in the order the DMA expects them
  typedef enum logic [4:0] {
    LOAD_IDLE,
    LOAD_DIM,
    LOAD_SLOTS,
    LOAD_SRC_DT,
    LOAD_DST_DT,
    LOAD_TOP_PAD,
    LOAD_BOTTOM_PAD,
    LOAD_LEFT_PAD,
    LOAD_RIGHT_PAD,
    LOAD_SRC_PTR,
    LOAD_DST_PTR,
    LOAD_SRC_INC_D1,
    LOAD_SRC_INC_D2,
    LOAD_DST_INC_D1,
    LOAD_DST_INC_D2,
    LOAD_SIZE_D2,
    LOAD_SIZE_D1,
    LOAD_DONE
  } load_step_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_GET,
    CTRL_LOAD
  } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/im2col_top.sv */
`timescale 1ns/1ps
`default_nettype none

module im2col_top
  import im2col_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  data_type_e            data_type_i,
  input  logic [STRIDE_W-1:0]   log_stride_i,
  input  logic [SLOT_W-1:0]     tx_slot_i,
  input  logic [SLOT_W-1:0]     rx_slot_i,
  input  logic [DMA_CH_NUM-1:0] ch_mask_i,
  input  logic                  irq_en_i,
  input  logic                  start_i,
  input  logic                  stream_end_i,
  input  logic                  irq_clear_i,
  input  logic                  desc_push_i,
  input  logic [PAD_W-1:0]      desc_top_pad_i,
  input  logic [PAD_W-1:0]      desc_bottom_pad_i,
  input  logic [PAD_W-1:0]      desc_left_pad_i,
  input  logic [PAD_W-1:0]      desc_right_pad_i,
  input  logic [31:0]           desc_in_ptr_i,
  input  logic [31:0]           desc_out_ptr_i,
  input  logic [INC_D2_W-1:0]   desc_in_inc_d2_i,
  input  logic [SIZE_W-1:0]     desc_size_d1_i,
  input  logic [SIZE_W-1:0]     desc_size_d2_i,
  output logic                  desc_full_o,
  output logic                  wr_req_o,
  output logic [31:0]           wr_addr_o,
  output logic [31:0]           wr_data_o,
  input  logic                  wr_done_i,
  input  logic [DMA_CH_NUM-1:0] dma_done_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  irq_o
);

  // FIFO head
  logic [PAD_W-1:0]    top_pad;
  logic [PAD_W-1:0]    bottom_pad;
  logic [PAD_W-1:0]    left_pad;
  logic [PAD_W-1:0]    right_pad;
  logic [31:0]         in_ptr;
  logic [31:0]         out_ptr;
  logic [INC_D2_W-1:0] in_inc_d2;
  logic [SIZE_W-1:0]   size_d1;
  logic [SIZE_W-1:0]   size_d2;
  logic                fifo_empty;
  logic                fifo_pop;

  logic [DMA_CH_IDX_W-1:0] free_ch;
  logic                    ch_full;
  logic                    ch_first_used;
  logic                    any_ch_busy;
  logic                    alloc;
  logic                    loader_idle;
  logic                    stream_closed;
  logic                    done;

  assign done_o = done;

  im2col_desc_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (desc_push_i),
    .pop_i        (fifo_pop),
    .top_pad_i    (desc_top_pad_i),
    .bottom_pad_i (desc_bottom_pad_i),
    .left_pad_i   (desc_left_pad_i),
    .right_pad_i  (desc_right_pad_i),
    .in_ptr_i     (desc_in_ptr_i),
    .out_ptr_i    (desc_out_ptr_i),
    .in_inc_d2_i  (desc_in_inc_d2_i),
    .size_d1_i    (desc_size_d1_i),
    .size_d2_i    (desc_size_d2_i),
    .top_pad_o    (top_pad),
    .bottom_pad_o (bottom_pad),
    .left_pad_o   (left_pad),
    .right_pad_o  (right_pad),
    .in_ptr_o     (in_ptr),
    .out_ptr_o    (out_ptr),
    .in_inc_d2_o  (in_inc_d2),
    .size_d1_o    (size_d1),
    .size_d2_o    (size_d2),
    .empty_o      (fifo_empty),
    .full_o       (desc_full_o)
  );

  // Channel state is reset by the start pulse and freed by the DMA
  im2col_channel_tracker u_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (start_i),
    .alloc_i      (alloc),
    .ch_mask_i    (ch_mask_i),
    .dma_done_i   (dma_done_i),
    .free_ch_o    (free_ch),
    .ch_full_o    (ch_full),
    .first_used_o (ch_first_used),
    .any_busy_o   (any_ch_busy)
  );

  im2col_dma_loader u_loader (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fifo_empty_i    (fifo_empty),
    .top_pad_i       (top_pad),
    .bottom_pad_i    (bottom_pad),
    .left_pad_i      (left_pad),
    .right_pad_i     (right_pad),
    .in_ptr_i        (in_ptr),
    .out_ptr_i       (out_ptr),
    .in_inc_d2_i     (in_inc_d2),
    .size_d1_i       (size_d1),
    .size_d2_i       (size_d2),
    .work_ch_i       (free_ch),
    .ch_full_i       (ch_full),
    .first_used_i    (ch_first_used),
    .stream_closed_i (stream_closed),
    .data_type_i     (data_type_i),
    .log_stride_i    (log_stride_i),
    .tx_slot_i       (tx_slot_i),
    .rx_slot_i       (rx_slot_i),
    .wr_done_i       (wr_done_i),
    .fifo_pop_o      (fifo_pop),
    .alloc_o         (alloc),
    .idle_o          (loader_idle),
    .wr_req_o        (wr_req_o),
    .wr_addr_o       (wr_addr_o),
    .wr_data_o       (wr_data_o)
  );

  im2col_completion u_completion (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (start_i),
    .stream_end_i    (stream_end_i),
    .fifo_empty_i    (fifo_empty),
    .loader_idle_i   (loader_idle),
    .any_ch_busy_i   (any_ch_busy),
    .irq_en_i        (irq_en_i),
    .irq_clear_i     (irq_clear_i),
    .stream_closed_o (stream_closed),
    .busy_o          (busy_o),
    .done_o          (done),
    .irq_o           (irq_o)
  );

endmodule

`default_nettype wire
